//--- build.f
hw/spiPkg.sv
hw/spiSckSync.sv
hw/spiFrameRx.sv
hw/apbBridge.sv
hw/csrRegFile.sv
hw/spiMisoTx.sv
hw/spiSlaveTop.sv
dv/spiSlaveTb.sv

//--- Makefile
# Verilator simulation of the SPI slave front end

VERILATOR ?= verilator
TOP       ?= spiSlaveTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR TIMESCALE VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- dv/spiSlaveTb.sv
module spiSlaveTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int regCount = 16;
	localparam int halfSck = 12;
	localparam int numFrames = 200;
	// Worst random step is a 6 word block write plus 4 readbacks of 3 words
	localparam int wordsMax = numFrames * 18 + 9 * 6;
	localparam int cycleLimit = wordsMax * 32 * 2 * halfSck + numFrames * 5 * 4 * halfSck + 5000;

	// Header command codes
	localparam logic [1:0] cmdRead = 2'd0;
	localparam logic [1:0] cmdWrite = 2'd1;
	localparam logic [1:0] cmdNop = 2'd2;
	localparam logic [1:0] cmdBlock = 2'd3;

	logic iSysClk;
	logic rst;
	logic spiSck;
	logic spiMosi;
	logic spiCsN;
	logic spiMiso;

	logic [31:0] lfsrState;
	int cycleCount = 0;
	logic [31:0] regModel [regCount];
	// Address, header, then up to 4 data words
	logic [31:0] txWords [6];
	logic [31:0] rxWords [6];

	spiSlaveTop #(
		.regCount  (regCount),
		.syncDepth (2)
	) dut_i (
		.iSysClk (iSysClk),
		.rst     (rst),
		.spiSck  (spiSck),
		.spiMosi (spiMosi),
		.spiCsN  (spiCsN),
		.spiMiso (spiMiso)
	);

	always #20 iSysClk = ~iSysClk;

	// Hang guard
	always @(posedge iSysClk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: the run went past %0d clock cycles", cycleLimit);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit taken
	task automatic randBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
	endtask

	task automatic halfWait();
		repeat (halfSck) @(negedge iSysClk);
	endtask

	task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		assert (got === expected)
		else
		begin
			$display("error: %0d ns: %s gave %h, expected %h", $time, what, got, expected);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// Mode 0 host
	// CS rises after stopBit bits when stopBit is nonzero
	task automatic spiTransfer(input int nWords, input int stopBit);
		int sent;
		sent = 0;
		spiCsN = 1'b0;
		halfWait();
		for (int w = 0; w < nWords; w++)
		begin
			rxWords[w] = '0;
			for (int b = 31; b >= 0; b--)
			begin
				if ((stopBit == 0) || (sent < stopBit))
				begin
					spiMosi = txWords[w][b];
					halfWait();
					// MISO taken at the rising SCK edge
					rxWords[w][b] = spiMiso;
					spiSck = 1'b1;
					halfWait();
					spiSck = 1'b0;
					sent++;
				end
			end
		end
		halfWait();
		spiCsN = 1'b1;
		// Gap so CS high clears the synchronizer
		halfWait();
		halfWait();
	endtask

	// Register model update for a completed frame
	task automatic applyWrites(input logic [31:0] addr, input logic [1:0] cmd, input int nData);
		logic [31:0] a;
		a = addr;
		for (int i = 0; i < nData; i++)
		begin
			// Register write keeps only the first word
			if ((cmd == cmdBlock) || ((cmd == cmdWrite) && (i == 0)))
			begin
				if (a < 32'(regCount))
				begin
					regModel[a[3:0]] = txWords[2 + i];
				end
			end
			if (cmd == cmdBlock)
			begin
				a = a + 32'd1;
			end
		end
	endtask

	task automatic runFrame(input logic [31:0] addr, input logic [1:0] cmd, input int nData,
		input int abortBit);
		logic [31:0] expRead;
		logic [31:0] expWord;
		txWords[0] = addr;
		txWords[1] = {6'b0, cmd, 16'(nData * 4), 8'h00};
		// Unmapped addresses read zero
		expRead = (addr < 32'(regCount)) ? regModel[addr[3:0]] : '0;
		spiTransfer(nData + 2, abortBit);
		if (abortBit == 0)
		begin
			for (int w = 0; w < nData + 2; w++)
			begin
				// All ones except the read word
				expWord = ((cmd == cmdRead) && (w == 2)) ? expRead : '1;
				checkValue(rxWords[w], expWord,
					$sformatf("MISO word %0d, cmd %0d at address %0d", w, cmd, addr));
			end
			applyWrites(addr, cmd, nData);
		end
		checkValue({31'b0, spiMiso}, 32'd1, "idle MISO");
	endtask

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	initial
	begin
		logic [31:0] r;
		logic [31:0] addr;
		logic [1:0] cmd;
		int nData;
		int abortBit;
		iSysClk = 1'b0;
		rst = 1'b1;
		spiSck = 1'b0;
		spiMosi = 1'b0;
		spiCsN = 1'b1;
		lfsrState = 32'h16227560;
		for (int i = 0; i < regCount; i++)
		begin
			regModel[i] = '0;
		end
		for (int i = 0; i < 6; i++)
		begin
			txWords[i] = '0;
		end
		repeat (3) @(posedge iSysClk);
		@(negedge iSysClk);
		rst = 1'b0;
		halfWait();
		checkValue({31'b0, spiMiso}, 32'd1, "MISO after reset");

		// Directed cases first
		runFrame(32'd5, cmdRead, 1, 0);
		txWords[2] = 32'hA5A50F0F;
		txWords[3] = 32'h0BADF00D;
		runFrame(32'd5, cmdWrite, 2, 0);
		runFrame(32'd5, cmdRead, 2, 0);
		txWords[2] = 32'h12345678;
		runFrame(32'd18, cmdWrite, 1, 0);
		runFrame(32'd18, cmdRead, 1, 0);
		runFrame(32'd5, cmdNop, 3, 0);
		// Cut off inside the header
		txWords[2] = 32'hDEADBEEF;
		runFrame(32'd5, cmdWrite, 1, 45);
		runFrame(32'd5, cmdRead, 1, 0);
		// Cut off inside the read word
		// A zero bit is left on top, so MISO has to go back high
		runFrame(32'd5, cmdRead, 1, 68);

		// Random frames with addresses past the register file
		for (int f = 0; f < numFrames; f++)
		begin
			randBits(2, r);
			cmd = r[1:0];
			randBits(5, r);
			addr = r % 20;
			randBits(2, r);
			nData = int'(r) + 1;
			for (int i = 0; i < 4; i++)
			begin
				randBits(32, r);
				txWords[2 + i] = r;
			end
			// About one frame in eight aborted in the address or header word
			abortBit = 0;
			randBits(3, r);
			if (r == 0)
			begin
				randBits(5, r);
				abortBit = (r == 0) ? 1 : int'(r);
				randBits(1, r);
				if (r[0])
				begin
					abortBit += 32;
				end
			end
			runFrame(addr, cmd, nData, abortBit);
			if ((cmd == cmdBlock) && (abortBit == 0))
			begin
				// Every word of the block read back
				for (int i = 0; i < nData; i++)
				begin
					runFrame(addr + 32'(i), cmdRead, 1, 0);
				end
			end
		end

		$display("All tests passed");
		$finish;
	end

endmodule

//--- hw/spiSlaveTop.sv
module spiSlaveTop #(
	parameter int regCount = spiPkg::defRegCount,
	parameter int syncDepth = spiPkg::defSyncDepth
) (
	input  logic  iSysClk,
	input  logic  rst,
	input  logic  spiSck,
	input  logic  spiMosi,
	input  logic  spiCsN,
	output logic  spiMiso
);

	//----------------------------------------------------------
	// Stage bundles
	//----------------------------------------------------------
	spiPkg::sckEvents  events;
	spiPkg::busReq     wordReq;
	spiPkg::apbReq     apbBus;
	spiPkg::apbRsp     apbRd;
	spiPkg::misoLoad   rdWord;

	// Pin synchronizer and edge flags
	spiSckSync #(
		.syncDepth (syncDepth)
	) sckSyncInst (
		.iSysClk (iSysClk),
		.rst     (rst),
		.spiSck  (spiSck),
		.spiMosi (spiMosi),
		.spiCsN  (spiCsN),
		.events  (events)
	);

	// Frame decode into word requests
	spiFrameRx frameRxInst (
		.iSysClk (iSysClk),
		.rst     (rst),
		.events  (events),
		.req     (wordReq)
	);

	// Word request to APB
	apbBridge bridgeInst (
		.iSysClk (iSysClk),
		.rst     (rst),
		.req     (wordReq),
		.apbOut  (apbBus),
		.apbIn   (apbRd),
		.rdOut   (rdWord)
	);

	csrRegFile #(
		.regCount (regCount)
	) regFileInst (
		.iSysClk (iSysClk),
		.rst     (rst),
		.apbIn   (apbBus),
		.apbOut  (apbRd)
	);

	// Read data back to the host
	spiMisoTx misoTxInst (
		.iSysClk (iSysClk),
		.rst     (rst),
		.events  (events),
		.load    (rdWord),
		.spiMiso (spiMiso)
	);

endmodule

//--- hw/spiMisoTx.sv
module spiMisoTx (
	input  logic              iSysClk,
	input  logic              rst,
	input  spiPkg::sckEvents  events,
	input  spiPkg::misoLoad   load,
	output logic              spiMiso
);

	// MSB drives the pin
	logic [31:0] shiftReg;

	//----------------------------------------------------------
	// Output shifter
	//----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			// Line idles high
			shiftReg <= '1;
		end
		else if (!events.csActive)
		begin
			// No frame, keep refilling with ones
			shiftReg <= '1;
		end
		else if (load.valid)
		begin
			// Lands before the first data phase rise
			shiftReg <= load.data;
		end
		else if (events.fall)
		begin
			// Mode 0, next bit after each falling edge
			// Ones shift in behind the word
			shiftReg <= {shiftReg[30:0], 1'b1};
		end
	end

	// Straight from the register, no gating
	always_comb
	begin
		spiMiso = shiftReg[31];
	end

endmodule

//--- hw/csrRegFile.sv
module csrRegFile #(
	parameter int regCount = spiPkg::defRegCount
) (
	input  logic           iSysClk,
	input  logic           rst,
	input  spiPkg::apbReq  apbIn,
	output spiPkg::apbRsp  apbOut
);

	// Word index width, at least one bit
	localparam int idxWidth = (regCount > 1) ? $clog2(regCount) : 1;

	logic [31:0]          regs [regCount];
	logic                 inRange;
	logic [idxWidth-1:0]  idx;
	logic                 accessPhase;
	logic                 wrEn;

	//----------------------------------------------------------
	// Address decode
	//----------------------------------------------------------
	always_comb
	begin
		// Word addresses, nothing above regCount-1
		inRange = (apbIn.paddr < 32'(regCount));
		idx = apbIn.paddr[idxWidth-1:0];
		accessPhase = apbIn.psel & apbIn.penable;
		wrEn = accessPhase & apbIn.pwrite & inRange;
	end

	//----------------------------------------------------------
	// Register array
	//----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			for (int i = 0; i < regCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn)
		begin
			// Out of range writes dropped by wrEn
			regs[idx] <= apbIn.pwdata;
		end
	end

	// Read data valid in the access phase
	always_comb
	begin
		if (accessPhase && !apbIn.pwrite && inRange)
		begin
			apbOut.prdata = regs[idx];
		end
		else
		begin
			// Unmapped addresses read as zero
			apbOut.prdata = '0;
		end
	end

endmodule

//--- hw/apbBridge.sv
module apbBridge (
	input  logic             iSysClk,
	input  logic             rst,
	input  spiPkg::busReq    req,
	output spiPkg::apbReq    apbOut,
	input  spiPkg::apbRsp    apbIn,
	output spiPkg::misoLoad  rdOut
);

	// Two phase APB sequence
	typedef enum logic [1:0] {
		phIdle   = 2'd0,
		phSetup  = 2'd1,
		phAccess = 2'd2
	} apbPhase;

	apbPhase        phase;
	spiPkg::busReq  held;

	//----------------------------------------------------------
	// Phase sequencer and read return
	//----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			phase <= phIdle;
			rdOut <= '0;
		end
		else
		begin
			rdOut.valid <= 1'b0;
			case (phase)
				phIdle:
				begin
					// Words arrive far apart, never busy here
					if (req.valid)
					begin
						phase <= phSetup;
					end
				end
				phSetup:
				begin
					phase <= phAccess;
				end
				phAccess:
				begin
					phase <= phIdle;
					// Slave answers in the access phase
					if (!held.write)
					begin
						rdOut.valid <= 1'b1;
						rdOut.data <= apbIn.prdata;
					end
				end
				default:
				begin
					phase <= phIdle;
				end
			endcase
		end
	end

	// Request held for the whole transfer
	always_ff @(posedge iSysClk)
	begin
		if ((phase == phIdle) && req.valid)
		begin
			held <= req;
		end
	end

	//----------------------------------------------------------
	// APB outputs
	//----------------------------------------------------------
	always_comb
	begin
		apbOut.psel = (phase != phIdle);
		apbOut.penable = (phase == phAccess);
		apbOut.pwrite = held.write;
		apbOut.paddr = held.addr;
		apbOut.pwdata = held.wdata;
	end

endmodule

//--- hw/spiFrameRx.sv
module spiFrameRx (
	input  logic              iSysClk,
	input  logic              rst,
	input  spiPkg::sckEvents  events,
	output spiPkg::busReq     req
);

	// Frame sequence: address, header, then data until CS rises
	typedef enum logic [1:0] {
		stAddr   = 2'd0,
		stHeader = 2'd1,
		stData   = 2'd2
	} frameState;

	frameState          state;
	logic [4:0]         bitCnt;
	logic               wordDone;
	logic               wordAct;
	logic               firstWord;
	logic               writeHit;
	spiPkg::headerWord  shiftWord;
	logic [31:0]        addr;
	spiPkg::spiCmd      cmd;

	// Completed word, only while the frame is still open
	always_comb
	begin
		wordAct = wordDone & events.csActive;
		// Register write takes one word, block write takes all
		writeHit = (cmd == spiPkg::cmdBlockWrite) ||
			((cmd == spiPkg::cmdRegWrite) && firstWord);
	end

	//----------------------------------------------------------
	// Sequencer and request generation
	//----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			state <= stAddr;
			bitCnt <= '0;
			wordDone <= 1'b0;
			firstWord <= 1'b0;
			req <= '0;
		end
		else
		begin
			// One clock pulses
			req.valid <= 1'b0;
			wordDone <= 1'b0;
			if (!events.csActive || events.frameStart)
			begin
				// Idle or fresh frame, drop any partial word
				state <= stAddr;
				bitCnt <= '0;
				firstWord <= 1'b0;
			end
			else
			begin
				// 32 falling edges per word
				if (events.fall)
				begin
					bitCnt <= bitCnt + 5'd1;
					wordDone <= (bitCnt == 5'd31);
				end
				if (wordAct)
				begin
					case (state)
						stAddr:
						begin
							state <= stHeader;
						end
						stHeader:
						begin
							state <= stData;
							firstWord <= 1'b1;
							// Read goes out right after the header
							if (shiftWord.fields.cmd == spiPkg::cmdRegRead)
							begin
								req.valid <= 1'b1;
								req.write <= 1'b0;
								req.addr <= addr;
								req.wdata <= '0;
							end
						end
						stData:
						begin
							firstWord <= 1'b0;
							if (writeHit)
							begin
								req.valid <= 1'b1;
								req.write <= 1'b1;
								req.addr <= addr;
								req.wdata <= shiftWord.raw;
							end
						end
						default:
						begin
							state <= stAddr;
						end
					endcase
				end
			end
		end
	end

	//----------------------------------------------------------
	// Word assembly and captured fields
	//----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		// MSB first, sampled on SCK rise
		if (events.rise)
		begin
			shiftWord.raw <= {shiftWord.raw[30:0], events.mosiBit};
		end
		if (wordAct)
		begin
			case (state)
				stAddr:   addr <= shiftWord.raw;
				// dataLen travels in the header, CS ends the frame
				stHeader: cmd <= shiftWord.fields.cmd;
				stData:
				begin
					// Next word of a block goes one address up
					if (cmd == spiPkg::cmdBlockWrite)
					begin
						addr <= addr + 32'd1;
					end
				end
				default:  addr <= addr;
			endcase
		end
	end

endmodule

//--- hw/spiSckSync.sv
module spiSckSync #(
	parameter int syncDepth = spiPkg::defSyncDepth
) (
	input  logic              iSysClk,
	input  logic              rst,
	input  logic              spiSck,
	input  logic              spiMosi,
	input  logic              spiCsN,
	output spiPkg::sckEvents  events
);

	//----------------------------------------------------------
	// Synchronizer chains
	//----------------------------------------------------------
	// Bits below syncDepth form the synchronizer
	// Top bit holds the previous synchronized value
	logic [syncDepth:0] sckPipe;
	logic [syncDepth:0] csPipe;
	logic [syncDepth:0] mosiPipe;

	// SCK idles low, CS idles high
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			sckPipe <= '0;
			csPipe <= '1;
		end
		else
		begin
			sckPipe <= {sckPipe[syncDepth-1:0], spiSck};
			csPipe <= {csPipe[syncDepth-1:0], spiCsN};
		end
	end

	// Data line
	always_ff @(posedge iSysClk)
	begin
		mosiPipe <= {mosiPipe[syncDepth-1:0], spiMosi};
	end

	//----------------------------------------------------------
	// Edge and frame flags
	//----------------------------------------------------------
	// Registered, so every flag lands syncDepth+1 clocks after the pin
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			events <= '0;
		end
		else
		begin
			events.rise <= sckPipe[syncDepth-1] & ~sckPipe[syncDepth];
			events.fall <= ~sckPipe[syncDepth-1] & sckPipe[syncDepth];
			events.csActive <= ~csPipe[syncDepth-1];
			// CS falling edge
			events.frameStart <= csPipe[syncDepth] & ~csPipe[syncDepth-1];
			// One clock older than the SCK edge, still mid bit
			events.mosiBit <= mosiPipe[syncDepth];
		end
	end

endmodule

//--- hw/spiPkg.sv
package spiPkg;

	//----------------------------------------------------------
	// Defaults for the top level parameters
	//----------------------------------------------------------
	localparam int defRegCount = 16;
	localparam int defSyncDepth = 2;

	// Command field of the header word
	typedef enum logic [1:0] {
		cmdRegRead    = 2'd0,
		cmdRegWrite   = 2'd1,
		cmdNop        = 2'd2,
		cmdBlockWrite = 2'd3
	} spiCmd;

	// Header word, shifted in raw and decoded by fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [5:0]  reserved;
			spiCmd       cmd;
			logic [15:0] dataLen;
			logic [7:0]  dummy;
		} fields;
	} headerWord;

	//----------------------------------------------------------
	// Stage to stage bundles
	//----------------------------------------------------------
	// Synchronized SCK edges and CS state
	typedef struct packed {
		logic rise;
		logic fall;
		logic csActive;
		logic frameStart;
		logic mosiBit;
	} sckEvents;

	// One word request toward the bus
	typedef struct packed {
		logic        valid;
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
	} busReq;

	// APB request side, no PREADY or PSLVERR
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] paddr;
		logic [31:0] pwdata;
	} apbReq;

	typedef struct packed {
		logic [31:0] prdata;
	} apbRsp;

	// Read word handed to the MISO shifter
	typedef struct packed {
		logic        valid;
		logic [31:0] data;
	} misoLoad;

endpackage
